//--- hw/spi_cfg_pkg.sv
`default_nettype none

package spi_cfg_pkg;

   // Width of the SCK divider field
   localparam int unsigned DIV_W = 8;

   // One SPI data byte, shared by queues, engine and bus side
   typedef logic [7:0] spi_byte_t;

   // Half period is div+1 clock cycles
   typedef logic [DIV_W-1:0] spi_div_t;

   // Bit position within the byte in flight
   typedef logic [2:0] spi_bit_cnt_t;

endpackage

`default_nettype wire

//--- hw/spi_bus_pkg.sv
`default_nettype none

package spi_bus_pkg;

   // Command kind, decoded from the 4-bit write mask of the A channel
   typedef enum logic [1:0] {
      CMD_READ = 2'd0,
      CMD_DATA = 2'd1,
      CMD_CTRL = 2'd2,
      CMD_NOP  = 2'd3
   } pb_cmd_e;

   // Control view of the write word
   typedef struct packed {
      logic [22:0] rsvd;
      logic        cs_en;
      logic [7:0]  div;
   } pb_ctrl_word_t;

   // Data view of the write word
   typedef struct packed {
      logic [23:0] rsvd;
      logic [7:0]  tx_byte;
   } pb_data_word_t;

   // One A data word, read either as control or as transmit data
   typedef union packed {
      pb_ctrl_word_t ctrl;
      pb_data_word_t data;
   } pb_wdata_u;

   // Status bits in the response word, byte sits in 7:0
   localparam int unsigned RESP_RX_VALID_BIT = 8;
   localparam int unsigned RESP_TX_FULL_BIT  = 9;
   localparam int unsigned RESP_BUSY_BIT     = 10;

   // Mask 0011 is control, 0001 is data, 0000 is read
   function automatic pb_cmd_e pb_decode_cmd(input logic [3:0] wmsk);
      case (wmsk)
         4'b0011: return CMD_CTRL;
         4'b0001: return CMD_DATA;
         4'b0000: return CMD_READ;
         default: return CMD_NOP;
      endcase
   endfunction

endpackage

`default_nettype wire

//--- hw/spi_byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_fifo
   import spi_cfg_pkg::*;
#(
   parameter int fifo_depth = 4
) (
   input  wire logic      clk,
   input  wire logic      rst_n,
   input  wire logic      push,
   input  wire spi_byte_t wdata,
   input  wire logic      pop,
   output spi_byte_t      rdata,
   output logic           full,
   output logic           empty
);

   localparam int AW = $clog2(fifo_depth);

   // Depth must be a power of two for the wrap bit to work
   if (fifo_depth < 2 || (fifo_depth & (fifo_depth - 1)) != 0) begin : g_depth_check
      $error("spi_byte_fifo depth must be a power of two of at least 2");
   end

   spi_byte_t       mem [fifo_depth];
   logic [AW:0]     wr_ptr;
   logic [AW:0]     rd_ptr;

   // Extra top bit tells full from empty when indexes meet
   assign empty = wr_ptr == rd_ptr;
   assign full  = wr_ptr[AW] != rd_ptr[AW] && wr_ptr[AW-1:0] == rd_ptr[AW-1:0];

   // Head of queue, always visible
   assign rdata = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[AW-1:0]] <= wdata;
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

//--- hw/spi_shift_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine
   import spi_cfg_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      rst_n,
   // Configuration
   input  wire logic      cs_en,
   input  wire spi_div_t  div,
   // Transmit queue
   input  wire spi_byte_t tx_rdata,
   input  wire logic      tx_empty,
   output logic           tx_pop,
   // Receive queue
   input  wire logic      rx_full,
   output logic           rx_push,
   output spi_byte_t      rx_wdata,
   // Status
   output logic           busy,
   // SPI pins
   output logic           spi_sck,
   output logic           spi_cs_n,
   output logic           spi_mosi,
   input  wire logic      spi_miso
);

   logic         start;
   logic         half_end;
   logic         byte_done;
   spi_div_t     div_q;
   spi_div_t     div_cnt;
   spi_bit_cnt_t bit_cnt;
   spi_byte_t    sh_tx;
   spi_byte_t    sh_rx;

   // A full receive queue stalls the transmit drain
   assign start  = !busy && cs_en && !tx_empty && !rx_full;
   assign tx_pop = start;

   // End of one SCK half period
   assign half_end = busy && !byte_done && div_cnt == div_q;

   // Mode 0, MSB first
   assign spi_mosi = sh_tx[7];

   // One cycle after the last fall the byte goes to the queue
   assign rx_push  = byte_done;
   assign rx_wdata = sh_rx;

   // Byte sequencing and SCK
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy      <= 1'b0;
         byte_done <= 1'b0;
         spi_sck   <= 1'b0;
         div_cnt   <= '0;
         bit_cnt   <= '0;
      end else if (start) begin
         busy    <= 1'b1;
         div_cnt <= '0;
         bit_cnt <= '0;
      end else if (busy) begin
         if (byte_done) begin
            busy      <= 1'b0;
            byte_done <= 1'b0;
         end else if (half_end) begin
            div_cnt <= '0;
            spi_sck <= !spi_sck;
            // Falling edge closes a bit
            if (spi_sck) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 3'd7) begin
                  byte_done <= 1'b1;
               end
            end
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

   // Select follows cs_en at once when set
   // Release waits for the byte in flight
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         spi_cs_n <= 1'b1;
      end else if (!busy || cs_en) begin
         spi_cs_n <= !cs_en;
      end
   end

   // Divider is latched so a byte keeps one rate
   always_ff @(posedge clk) begin
      if (start) begin
         div_q <= div;
      end
   end

   // Transmit shifter, next bit appears after each fall
   always_ff @(posedge clk) begin
      if (start) begin
         sh_tx <= tx_rdata;
      end else if (half_end && spi_sck) begin
         sh_tx <= {sh_tx[6:0], 1'b0};
      end
   end

   // MISO is taken together with the rising edge
   always_ff @(posedge clk) begin
      if (half_end && !spi_sck) begin
         sh_rx <= {sh_rx[6:0], spi_miso};
      end
   end

   a_sck_idle: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> !spi_sck);
   a_rx_room: assert property (@(posedge clk) disable iff (!rst_n) rx_push |-> !rx_full);

endmodule

`default_nettype wire

//--- hw/spi_pb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_pb_regs
   import spi_bus_pkg::*;
   import spi_cfg_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst_n,
   // A channel
   input  wire logic        pb_spi_avalid,
   output logic             pb_spi_aready,
   input  wire logic [3:0]  pb_spi_awmsk,
   input  wire logic [31:0] pb_spi_adata,
   // B channel
   output logic [31:0]      pb_spi_bdata,
   output logic             pb_spi_bvalid,
   input  wire logic        pb_spi_bready,
   // Transmit queue
   output logic             tx_push,
   output spi_byte_t        tx_wdata,
   input  wire logic        tx_full,
   // Receive queue
   output logic             rx_pop,
   input  wire spi_byte_t   rx_rdata,
   input  wire logic        rx_empty,
   // Engine
   output logic             cs_en,
   output spi_div_t         div,
   input  wire logic        busy
);

   pb_cmd_e     cmd;
   pb_wdata_u   wword;
   logic        a_hs;
   logic        b_hs;
   logic [31:0] resp_word;

   assign cmd   = pb_decode_cmd(pb_spi_awmsk);
   assign wword = pb_spi_adata;

   // One command in flight, data writes also wait for room in the queue
   assign pb_spi_aready = !pb_spi_bvalid && !(cmd == CMD_DATA && tx_full);

   assign a_hs = pb_spi_avalid && pb_spi_aready;
   assign b_hs = pb_spi_bvalid && pb_spi_bready;

   // Queue strobes
   assign tx_push  = a_hs && cmd == CMD_DATA;
   assign tx_wdata = wword.data.tx_byte;
   // Read of an empty queue just reports status
   assign rx_pop   = a_hs && cmd == CMD_READ && !rx_empty;

   // Status as seen at the transfer edge
   always_comb begin
      resp_word = '0;
      if (cmd == CMD_READ && !rx_empty) begin
         resp_word[7:0] = rx_rdata;
      end
      resp_word[RESP_RX_VALID_BIT] = !rx_empty;
      resp_word[RESP_TX_FULL_BIT]  = tx_full;
      resp_word[RESP_BUSY_BIT]     = busy;
   end

   // Control register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cs_en <= 1'b0;
         div   <= '0;
      end else if (a_hs && cmd == CMD_CTRL) begin
         cs_en <= wword.ctrl.cs_en;
         div   <= spi_div_t'(wword.ctrl.div);
      end
   end

   // Response valid, set by a transfer and cleared when taken
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pb_spi_bvalid <= 1'b0;
      end else if (a_hs) begin
         pb_spi_bvalid <= 1'b1;
      end else if (b_hs) begin
         pb_spi_bvalid <= 1'b0;
      end
   end

   // Response word
   always_ff @(posedge clk) begin
      if (a_hs) begin
         pb_spi_bdata <= resp_word;
      end
   end

   // A pending response holds its word until the B transfer
   a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      pb_spi_bvalid && !pb_spi_bready |=> pb_spi_bvalid && $stable(pb_spi_bdata));

endmodule

`default_nettype wire

//--- hw/spi_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master_top
   import spi_cfg_pkg::*;
#(
   parameter int fifo_depth = 4
) (
   input  wire logic        clk,
   input  wire logic        rst_n,
   // A channel
   input  wire logic        pb_spi_avalid,
   output logic             pb_spi_aready,
   input  wire logic [3:0]  pb_spi_awmsk,
   input  wire logic [31:0] pb_spi_adata,
   // B channel
   output logic [31:0]      pb_spi_bdata,
   output logic             pb_spi_bvalid,
   input  wire logic        pb_spi_bready,
   // SPI pins
   output logic             spi_sck,
   output logic             spi_cs_n,
   output logic             spi_mosi,
   input  wire logic        spi_miso
);

   // Transmit queue
   logic      tx_push;
   logic      tx_pop;
   logic      tx_full;
   logic      tx_empty;
   spi_byte_t tx_wdata;
   spi_byte_t tx_rdata;
   // Receive queue
   logic      rx_push;
   logic      rx_pop;
   logic      rx_full;
   logic      rx_empty;
   spi_byte_t rx_wdata;
   spi_byte_t rx_rdata;
   // Engine control and status
   logic      cs_en;
   spi_div_t  div;
   logic      busy;

   spi_pb_regs u_regs (
      .clk(clk), .rst_n(rst_n),
      .pb_spi_avalid(pb_spi_avalid), .pb_spi_aready(pb_spi_aready),
      .pb_spi_awmsk(pb_spi_awmsk), .pb_spi_adata(pb_spi_adata),
      .pb_spi_bdata(pb_spi_bdata), .pb_spi_bvalid(pb_spi_bvalid),
      .pb_spi_bready(pb_spi_bready),
      .tx_push(tx_push), .tx_wdata(tx_wdata), .tx_full(tx_full),
      .rx_pop(rx_pop), .rx_rdata(rx_rdata), .rx_empty(rx_empty),
      .cs_en(cs_en), .div(div), .busy(busy)
   );

   spi_byte_fifo #(.fifo_depth(fifo_depth)) tx_fifo (
      .clk(clk), .rst_n(rst_n),
      .push(tx_push), .wdata(tx_wdata), .pop(tx_pop),
      .rdata(tx_rdata), .full(tx_full), .empty(tx_empty)
   );

   spi_byte_fifo #(.fifo_depth(fifo_depth)) rx_fifo (
      .clk(clk), .rst_n(rst_n),
      .push(rx_push), .wdata(rx_wdata), .pop(rx_pop),
      .rdata(rx_rdata), .full(rx_full), .empty(rx_empty)
   );

   spi_shift_engine u_engine (
      .clk(clk), .rst_n(rst_n),
      .cs_en(cs_en), .div(div),
      .tx_rdata(tx_rdata), .tx_empty(tx_empty), .tx_pop(tx_pop),
      .rx_full(rx_full), .rx_push(rx_push), .rx_wdata(rx_wdata),
      .busy(busy),
      .spi_sck(spi_sck), .spi_cs_n(spi_cs_n),
      .spi_mosi(spi_mosi), .spi_miso(spi_miso)
   );

endmodule

`default_nettype wire

//--- tb/spi_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_clock_gen #(
   parameter real period_ns = 20.0
) (
   output logic clk
);

   // Free running, starts low
   initial begin
      clk = 1'b0;
      forever begin
         #(period_ns / 2.0);
         clk = ~clk;
      end
   end

endmodule

`default_nettype wire

//--- tb/spi_master_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master_tb
   import spi_bus_pkg::*;
();

   localparam int FIFO_DEPTH   = 4;
   localparam int NROWS        = 4;
   localparam int NRAND        = FIFO_DEPTH + 1;
   localparam int AREADY_LIMIT = 200;
   localparam int POLL_LIMIT   = 100;
   localparam int WATCHDOG_NS  = 200000;
   localparam logic [3:0] MSK_CTRL = 4'b0011;
   localparam logic [3:0] MSK_DATA = 4'b0001;
   localparam logic [3:0] MSK_READ = 4'b0000;

   logic        clk;
   logic        rst_n;
   logic        pb_spi_avalid;
   logic        pb_spi_aready;
   logic [3:0]  pb_spi_awmsk;
   logic [31:0] pb_spi_adata;
   logic [31:0] pb_spi_bdata;
   logic        pb_spi_bvalid;
   logic        pb_spi_bready;
   logic        spi_sck;
   logic        spi_cs_n;
   logic        spi_mosi;
   logic        spi_miso;

   // Stimulus table, one row is {div, tx byte, slave reply}
   logic [23:0] stim_table [NROWS];
   logic [7:0]  rnd_tx [NRAND];
   logic [7:0]  rnd_rx [NRAND];
   logic [31:0] rnd_word;
   logic [31:0] resp;
   logic [7:0]  row_div;
   integer      seed;
   int          i;
   int          held;

   // Slave model state
   logic [7:0]  reply_q [$];
   logic [7:0]  mosi_q [$];
   logic [7:0]  slv_tx = 8'h00;
   logic [7:0]  slv_rx = 8'h00;
   logic        slv_loaded = 1'b0;
   int          slv_rises = 0;
   int          slv_falls = 0;
   int          cyc = 0;
   int          first_rise = 0;
   int          rise_gap = 0;

   spi_clock_gen #(.period_ns(20.0)) u_clk (.clk(clk));

   spi_master_top #(.fifo_depth(FIFO_DEPTH)) uut (
      .clk(clk), .rst_n(rst_n),
      .pb_spi_avalid(pb_spi_avalid), .pb_spi_aready(pb_spi_aready),
      .pb_spi_awmsk(pb_spi_awmsk), .pb_spi_adata(pb_spi_adata),
      .pb_spi_bdata(pb_spi_bdata), .pb_spi_bvalid(pb_spi_bvalid),
      .pb_spi_bready(pb_spi_bready),
      .spi_sck(spi_sck), .spi_cs_n(spi_cs_n),
      .spi_mosi(spi_mosi), .spi_miso(spi_miso)
   );

   // Mode 0 slave, MSB first
   assign spi_miso = slv_tx[7];

   // Clock cycle count for SCK period measurement
   always @(posedge clk) begin
      cyc = cyc + 1;
   end

   // Capture MOSI on each rise and time the first two rises of a byte
   always @(posedge spi_sck) begin
      if (!spi_cs_n) begin
         slv_rx = {slv_rx[6:0], spi_mosi};
         if (slv_rises == 0) begin
            first_rise = cyc;
         end else if (slv_rises == 1) begin
            rise_gap = cyc - first_rise;
         end
         slv_rises = slv_rises + 1;
         if (slv_rises == 8) begin
            mosi_q.push_back(slv_rx);
            slv_rises = 0;
         end
      end
   end

   // Next reply bit after each fall, next reply byte after the eighth
   always @(negedge spi_sck) begin
      if (!spi_cs_n) begin
         slv_falls = slv_falls + 1;
         if (slv_falls == 8) begin
            slv_falls = 0;
            if (reply_q.size() > 0) begin
               slv_tx     = reply_q.pop_front();
               slv_loaded = 1'b1;
            end else begin
               slv_tx     = 8'h00;
               slv_loaded = 1'b0;
            end
         end else begin
            slv_tx = {slv_tx[6:0], 1'b0};
         end
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("Mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // Response layout, byte in 7:0 plus three status bits
   function automatic logic [31:0] status_word(input logic rx_valid, input logic tx_full,
                                               input logic busy, input logic [7:0] rx_byte);
      logic [31:0] w;
      w = 32'h0;
      w[7:0] = rx_byte;
      w[RESP_RX_VALID_BIT] = rx_valid;
      w[RESP_TX_FULL_BIT]  = tx_full;
      w[RESP_BUSY_BIT]     = busy;
      return w;
   endfunction

   function automatic logic [31:0] ctrl_word(input logic cs_en, input logic [7:0] div);
      return {23'h0, cs_en, div};
   endfunction

   // Idle slave takes the byte at once, otherwise it waits in line
   task automatic queue_reply(input logic [7:0] b);
      if (!slv_loaded && slv_falls == 0) begin
         slv_tx     = b;
         slv_loaded = 1'b1;
      end else begin
         reply_q.push_back(b);
      end
   endtask

   // One command and its response
   task automatic bus_xfer(input logic [3:0] wmsk, input logic [31:0] data,
                           output logic [31:0] rsp);
      int waited;
      waited = 0;
      @(negedge clk);
      pb_spi_avalid = 1'b1;
      pb_spi_awmsk  = wmsk;
      pb_spi_adata  = data;
      #1;
      while (!pb_spi_aready) begin
         waited = waited + 1;
         if (waited > AREADY_LIMIT) begin
            abort_run("Timeout waiting for the bus to accept a command");
         end
         @(negedge clk);
         #1;
      end
      // Transfer on the coming rise, response one cycle later
      @(negedge clk);
      pb_spi_avalid = 1'b0;
      check_val("pb_spi_bvalid", pb_spi_bvalid, 1'b1);
      rsp = pb_spi_bdata;
      // Response stays put while bready is low, no new command taken
      @(negedge clk);
      check_val("pb_spi_bvalid", pb_spi_bvalid, 1'b1);
      check_val("pb_spi_bdata", pb_spi_bdata, rsp);
      check_val("pb_spi_aready", pb_spi_aready, 1'b0);
      pb_spi_bready = 1'b1;
      @(negedge clk);
      pb_spi_bready = 1'b0;
   endtask

   // Reads until a byte shows up
   task automatic read_rx(output logic [31:0] rsp);
      int polls;
      polls = 0;
      rsp = 32'h0;
      while (!rsp[RESP_RX_VALID_BIT]) begin
         if (polls == POLL_LIMIT) begin
            abort_run("Timeout waiting for a received byte");
         end
         bus_xfer(MSK_READ, 32'h0, rsp);
         polls = polls + 1;
      end
   endtask

   task automatic slave_byte_check(input logic [7:0] exp);
      if (mosi_q.size() == 0) begin
         abort_run("The slave captured no byte on MOSI");
      end
      check_val("spi_mosi byte", mosi_q.pop_front(), exp);
   endtask

   // Guard against a stalled clock loop
   initial begin
      #(WATCHDOG_NS);
      abort_run("Simulation did not finish within its time limit");
   end

   initial begin
      rst_n         = 1'b0;
      pb_spi_avalid = 1'b0;
      pb_spi_awmsk  = 4'h0;
      pb_spi_adata  = 32'h0;
      pb_spi_bready = 1'b0;
      stim_table[0] = 24'h00_A5_3C;
      stim_table[1] = 24'h01_5A_C3;
      stim_table[2] = 24'h03_81_7E;
      stim_table[3] = 24'h02_F0_0F;
      seed = 37469;
      for (i = 0; i < NRAND; i++) begin
         rnd_word  = $random(seed);
         rnd_tx[i] = rnd_word[7:0];
         rnd_word  = $random(seed);
         rnd_rx[i] = rnd_word[7:0];
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Idle state after reset
      check_val("spi_cs_n", spi_cs_n, 1'b1);
      check_val("spi_sck", spi_sck, 1'b0);
      check_val("pb_spi_bvalid", pb_spi_bvalid, 1'b0);
      bus_xfer(MSK_READ, 32'h0, resp);
      check_val("pb_spi_bdata", resp, status_word(1'b0, 1'b0, 1'b0, 8'h00));

      // Select on
      bus_xfer(MSK_CTRL, ctrl_word(1'b1, 8'd0), resp);
      check_val("pb_spi_bdata", resp, status_word(1'b0, 1'b0, 1'b0, 8'h00));
      check_val("spi_cs_n", spi_cs_n, 1'b0);

      // Table rows, one byte each
      for (i = 0; i < NROWS; i++) begin
         row_div  = stim_table[i][23:16];
         rise_gap = 0;
         queue_reply(stim_table[i][7:0]);
         bus_xfer(MSK_CTRL, ctrl_word(1'b1, row_div), resp);
         check_val("pb_spi_bdata", resp, status_word(1'b0, 1'b0, 1'b0, 8'h00));
         bus_xfer(MSK_DATA, {24'h0, stim_table[i][15:8]}, resp);
         check_val("pb_spi_bdata", resp, status_word(1'b0, 1'b0, 1'b0, 8'h00));
         read_rx(resp);
         check_val("pb_spi_bdata", resp, status_word(1'b1, 1'b0, 1'b0, stim_table[i][7:0]));
         slave_byte_check(stim_table[i][15:8]);
         check_val("spi_sck rise gap", rise_gap, 2 * (row_div + 1));
      end

      // Select off, queue fills with nothing draining
      bus_xfer(MSK_CTRL, ctrl_word(1'b0, 8'd1), resp);
      check_val("spi_cs_n", spi_cs_n, 1'b1);
      for (i = 0; i < FIFO_DEPTH; i++) begin
         queue_reply(rnd_rx[i]);
         bus_xfer(MSK_DATA, {24'h0, rnd_tx[i]}, resp);
         check_val("pb_spi_bdata", resp, status_word(1'b0, 1'b0, 1'b0, 8'h00));
      end
      bus_xfer(MSK_READ, 32'h0, resp);
      check_val("pb_spi_bdata", resp, status_word(1'b0, 1'b1, 1'b0, 8'h00));

      // One more data write is held off while full
      queue_reply(rnd_rx[NRAND-1]);
      @(negedge clk);
      pb_spi_avalid = 1'b1;
      pb_spi_awmsk  = MSK_DATA;
      pb_spi_adata  = {24'h0, rnd_tx[NRAND-1]};
      for (held = 0; held < 8; held++) begin
         #1;
         check_val("pb_spi_aready", pb_spi_aready, 1'b0);
         @(negedge clk);
      end
      pb_spi_avalid = 1'b0;

      // Enable drains a byte and frees a slot
      bus_xfer(MSK_CTRL, ctrl_word(1'b1, 8'd1), resp);
      check_val("pb_spi_bdata", resp, status_word(1'b0, 1'b1, 1'b0, 8'h00));
      bus_xfer(MSK_DATA, {24'h0, rnd_tx[NRAND-1]}, resp);
      check_val("pb_spi_bdata tx_full", resp[RESP_TX_FULL_BIT], 1'b0);
      check_val("pb_spi_bdata busy", resp[RESP_BUSY_BIT], 1'b1);

      // Bytes come back in the order sent
      for (i = 0; i < NRAND; i++) begin
         read_rx(resp);
         check_val("pb_spi_bdata rx byte", resp[7:0], rnd_rx[i]);
         slave_byte_check(rnd_tx[i]);
      end

      // Empty receive queue
      bus_xfer(MSK_READ, 32'h0, resp);
      check_val("pb_spi_bdata", resp, status_word(1'b0, 1'b0, 1'b0, 8'h00));

      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- spi_master_top.f
hw/spi_cfg_pkg.sv
hw/spi_bus_pkg.sv
hw/spi_byte_fifo.sv
hw/spi_shift_engine.sv
hw/spi_pb_regs.sv
hw/spi_master_top.sv
tb/spi_clock_gen.sv
tb/spi_master_tb.sv

//--- Bender.yml
package:
  name: spi_master

sources:
  # Packages first, then leaf modules, then the top level
  - files:
      - hw/spi_cfg_pkg.sv
      - hw/spi_bus_pkg.sv
      - hw/spi_byte_fifo.sv
      - hw/spi_shift_engine.sv
      - hw/spi_pb_regs.sv
      - hw/spi_master_top.sv
  - target: test
    files:
      - tb/spi_clock_gen.sv
      - tb/spi_master_tb.sv
